/* common/scrub_pkg.sv */
// Widths, control and status field positions, constants and payload types shared by the scrubber RTL

package scrub_pkg;

  // ------------------------------------------------------------
  // Channel and address sizing
  // ------------------------------------------------------------

  localparam int NUM_CHAN = 4;
  localparam int CHAN_W   = $clog2(NUM_CHAN);
  localparam int ADDR_W   = 16;

  // Last channel index, so channel 0 wins the first round-robin pick
  localparam logic [CHAN_W-1:0] CHAN_LAST = CHAN_W'(NUM_CHAN - 1);

  // Region swept by every engine, scaled down for simulation
  localparam logic [ADDR_W-1:0] SCRB_MAX_ADDR  = 16'h01FF;
  localparam int                SCRB_BURST_LEN = 16;
  localparam logic [ADDR_W-1:0] BURST_STEP     = ADDR_W'(SCRB_BURST_LEN);

  // Reset synchronizer depth ahead of the final two flops
  localparam int RST_STAGES = 4;

  // ------------------------------------------------------------
  // Control word ctl0
  // ------------------------------------------------------------

  // Bit 31 debug enable, bits 30:28 debug channel select
  // Bits 3:0 carry one scrub enable per channel
  localparam int CTL_DBG_EN_BIT  = 31;
  localparam int CTL_DBG_SEL_LSB = 28;
  localparam int DBG_SEL_W       = 3;

  // ------------------------------------------------------------
  // Status word and ID readout
  // ------------------------------------------------------------

  localparam logic [19:0] STAT_FILLER = 20'hA1111;
  localparam logic [3:0]  STAT_MARK   = 4'hF;
  localparam logic [31:0] CL_ID0      = 32'h1D0F_ABCD;

  // Engine FSM encoding, also reported in the status word
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    REQ      = 3'd1,
    WAIT_REL = 3'd2,
    NEXT     = 3'd3,
    DONE     = 3'd4
  } scrb_state_e;

  // Per-channel status returned to the control block
  typedef struct packed {
    scrb_state_e       state;
    logic              done;
    logic [ADDR_W-1:0] addr;
  } scrb_stat_t;

  // Burst request presented on the shared memory port
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [CHAN_W-1:0] chan;
  } mem_req_t;

endpackage

/* design/reset_flr.sv */
// Reset synchronizer feeding every block, plus the function-level-reset done response
`timescale 1ns/1ps

module reset_flr
(
  input  logic clk,
  input  logic rst_main_n,
  input  logic flr_assert,
  output logic sync_rst_n,
  output logic flr_done
);

  logic [scrub_pkg::RST_STAGES-1:0] rst_pipe;
  logic                             pipe_rst_n;
  logic                             pre_sync_rst_n;
  logic                             flr_assert_q;

  // Staged release of the raw reset, cleared at once on assertion
  always_ff @(posedge clk or negedge rst_main_n)
    if (!rst_main_n)
      rst_pipe <= '0;
    else
      rst_pipe <= {rst_pipe[scrub_pkg::RST_STAGES-2:0], 1'b1};

  assign pipe_rst_n = rst_pipe[scrub_pkg::RST_STAGES-1];

  always_ff @(posedge clk or negedge pipe_rst_n)
    if (!pipe_rst_n)
    begin
      pre_sync_rst_n <= 1'b0;
      sync_rst_n     <= 1'b0;
    end
    else
    begin
      pre_sync_rst_n <= 1'b1;
      sync_rst_n     <= pre_sync_rst_n;
    end

  // FLR handshake, done pulses every other cycle while the request is held
  always_ff @(posedge clk or negedge sync_rst_n)
    if (!sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end

endmodule

/* design/scrub_ctrl_status.sv */
// Control word register, registered status word and debug ID readout for the scrub channels
`timescale 1ns/1ps

module scrub_ctrl_status
(
  input  logic                                        clk,
  input  logic                                        sync_rst_n,
  input  logic [31:0]                                 ctl0,
  input  logic [scrub_pkg::NUM_CHAN-1:0]              mem_ready,
  input  scrub_pkg::scrb_stat_t [scrub_pkg::NUM_CHAN-1:0] chan_stat,
  output logic [scrub_pkg::NUM_CHAN-1:0]              enable,
  output logic [31:0]                                 status0,
  output logic [31:0]                                 dbg_id
);

  logic [31:0]                     ctl0_q;
  logic [scrub_pkg::NUM_CHAN-1:0]  ready_q;
  logic                            dbg_en;
  logic [scrub_pkg::DBG_SEL_W-1:0] dbg_sel;
  logic [scrub_pkg::CHAN_W-1:0]    dbg_chan;
  logic [scrub_pkg::NUM_CHAN-1:0]  done_vec;
  logic [19:0]                     state_field;
  logic [31:0]                     status_nxt;
  logic [31:0]                     id_nxt;

  // ------------------------------------------------------------
  // Control word
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge sync_rst_n)
    if (!sync_rst_n)
    begin
      ctl0_q  <= '0;
      ready_q <= '0;
    end
    else
    begin
      ctl0_q  <= ctl0;
      ready_q <= mem_ready;
    end

  assign enable  = ctl0_q[scrub_pkg::NUM_CHAN-1:0];
  assign dbg_en  = ctl0_q[scrub_pkg::CTL_DBG_EN_BIT];
  assign dbg_sel = ctl0_q[scrub_pkg::CTL_DBG_SEL_LSB +: scrub_pkg::DBG_SEL_W];

  // Out of range selects fall back to channel 0
  assign dbg_chan = (dbg_sel < scrub_pkg::NUM_CHAN) ? dbg_sel[scrub_pkg::CHAN_W-1:0] : '0;

  // ------------------------------------------------------------
  // Status word
  // ------------------------------------------------------------

  // Debug view puts each 3-bit state in its own nibble above a zero nibble
  always_comb
  begin
    state_field = '0;
    done_vec    = '0;
    for (int i = 0; i < scrub_pkg::NUM_CHAN; i++)
    begin
      state_field[4 + 4*i +: 3] = chan_stat[i].state;
      done_vec[i]               = chan_stat[i].done;
    end
  end

  assign status_nxt = {dbg_en ? state_field : scrub_pkg::STAT_FILLER,
                       scrub_pkg::STAT_MARK, done_vec, ready_q};

  assign id_nxt = dbg_en ? {{(32-scrub_pkg::ADDR_W){1'b0}}, chan_stat[dbg_chan].addr}
                         : scrub_pkg::CL_ID0;

  always_ff @(posedge clk or negedge sync_rst_n)
    if (!sync_rst_n)
    begin
      status0 <= {scrub_pkg::STAT_FILLER, scrub_pkg::STAT_MARK,
                  {(2*scrub_pkg::NUM_CHAN){1'b0}}};
      dbg_id  <= scrub_pkg::CL_ID0;
    end
    else
    begin
      status0 <= status_nxt;
      dbg_id  <= id_nxt;
    end

endmodule

/* design/scrub_top.sv */
// Scrubber top level joining reset, four scrub engines, the port arbiter and control/status
`timescale 1ns/1ps

module scrub_top
(
  input  logic                           clk,
  input  logic                           rst_main_n,
  input  logic [31:0]                    ctl0,
  input  logic [scrub_pkg::NUM_CHAN-1:0] mem_ready,
  input  logic                           flr_assert,
  input  logic                           mem_ack,
  output logic                           mem_req,
  output scrub_pkg::mem_req_t            mem_cmd,
  output logic [31:0]                    status0,
  output logic [31:0]                    dbg_id,
  output logic                           flr_done
);

  logic                                                  sync_rst_n;
  logic [scrub_pkg::NUM_CHAN-1:0]                        enable;
  logic [scrub_pkg::NUM_CHAN-1:0]                        chan_req;
  logic [scrub_pkg::NUM_CHAN-1:0]                        chan_ack;
  logic [scrub_pkg::NUM_CHAN-1:0][scrub_pkg::ADDR_W-1:0] chan_addr;
  scrub_pkg::scrb_stat_t [scrub_pkg::NUM_CHAN-1:0]       chan_stat;

  reset_flr i_reset_flr
  (
    .clk        (clk),
    .rst_main_n (rst_main_n),
    .flr_assert (flr_assert),
    .sync_rst_n (sync_rst_n),
    .flr_done   (flr_done)
  );

  // ------------------------------------------------------------
  // Scrub channels
  // ------------------------------------------------------------

  for (genvar i = 0; i < scrub_pkg::NUM_CHAN; i++)
  begin : g_engine
    scrub_engine i_scrub_engine
    (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .enable     (enable[i]),
      .ack        (chan_ack[i]),
      .req        (chan_req[i]),
      .addr       (chan_addr[i]),
      .stat       (chan_stat[i])
    );
  end

  scrub_arbiter i_scrub_arbiter
  (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .chan_req   (chan_req),
    .chan_addr  (chan_addr),
    .chan_ack   (chan_ack),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_ack    (mem_ack)
  );

  scrub_ctrl_status i_scrub_ctrl_status
  (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .ctl0       (ctl0),
    .mem_ready  (mem_ready),
    .chan_stat  (chan_stat),
    .enable     (enable),
    .status0    (status0),
    .dbg_id     (dbg_id)
  );

endmodule

/* scrubber/scrub_arbiter.sv */
// Round-robin arbiter that shares one four-phase memory request port among the scrub engines
`timescale 1ns/1ps

module scrub_arbiter
(
  input  logic                                                  clk,
  input  logic                                                  sync_rst_n,
  input  logic [scrub_pkg::NUM_CHAN-1:0]                        chan_req,
  input  logic [scrub_pkg::NUM_CHAN-1:0][scrub_pkg::ADDR_W-1:0] chan_addr,
  output logic [scrub_pkg::NUM_CHAN-1:0]                        chan_ack,
  output logic                                                  mem_req,
  output scrub_pkg::mem_req_t                                   mem_cmd,
  input  logic                                                  mem_ack
);

  logic                                busy;
  logic [scrub_pkg::NUM_CHAN-1:0]      grant;
  logic [scrub_pkg::CHAN_W-1:0]        last_chan;
  logic [scrub_pkg::CHAN_W-1:0]        pick_chan;
  logic                                pick_vld;

  // First waiting channel after the last one granted, in cyclic order
  always_comb
  begin : rr_pick
    logic [scrub_pkg::CHAN_W-1:0] idx;
    pick_vld  = 1'b0;
    pick_chan = last_chan;
    for (int off = 0; off < scrub_pkg::NUM_CHAN; off++)
    begin
      idx = last_chan + 1'b1 + off[scrub_pkg::CHAN_W-1:0];
      if (!pick_vld && chan_req[idx])
      begin
        pick_vld  = 1'b1;
        pick_chan = idx;
      end
    end
  end

  // ------------------------------------------------------------
  // Port handshake
  // ------------------------------------------------------------

  // busy with mem_req high waits for ack, busy with mem_req low waits for release
  always_ff @(posedge clk or negedge sync_rst_n)
    if (!sync_rst_n)
    begin
      busy      <= 1'b0;
      mem_req   <= 1'b0;
      grant     <= '0;
      last_chan <= scrub_pkg::CHAN_LAST;
    end
    else if (!busy)
    begin
      if (pick_vld)
      begin
        busy      <= 1'b1;
        mem_req   <= 1'b1;
        grant     <= {{(scrub_pkg::NUM_CHAN-1){1'b0}}, 1'b1} << pick_chan;
        last_chan <= pick_chan;
      end
    end
    else if (mem_req)
    begin
      if (mem_ack)
        mem_req <= 1'b0;
    end
    else if (!mem_ack)
    begin
      busy  <= 1'b0;
      grant <= '0;
    end

  always_ff @(posedge clk)
    if (!busy && pick_vld)
    begin
      mem_cmd.addr <= chan_addr[pick_chan];
      mem_cmd.chan <= pick_chan;
    end

  // Ack is steered back to the granted engine only
  assign chan_ack = grant & {scrub_pkg::NUM_CHAN{mem_ack}};

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  a_grant_onehot : assert property (@(posedge clk) disable iff (!sync_rst_n)
    $onehot0(grant))
    else $error("scrub_arbiter grant is not one-hot");

  a_cmd_stable : assert property (@(posedge clk) disable iff (!sync_rst_n)
    mem_req |=> !mem_req || $stable(mem_cmd))
    else $error("scrub_arbiter mem_cmd moved while mem_req was high");

endmodule

/* scrubber/scrub_engine.sv */
// One scrub channel that sweeps its region burst by burst over a four-phase request port
`timescale 1ns/1ps

module scrub_engine
(
  input  logic                         clk,
  input  logic                         sync_rst_n,
  input  logic                         enable,
  input  logic                         ack,
  output logic                         req,
  output logic [scrub_pkg::ADDR_W-1:0] addr,
  output scrub_pkg::scrb_stat_t        stat
);

  scrub_pkg::scrb_state_e       state;
  scrub_pkg::scrb_state_e       state_nxt;
  logic [scrub_pkg::ADDR_W-1:0] addr_nxt;
  logic [scrub_pkg::ADDR_W-1:0] addr_step;

  assign addr_step = addr + scrub_pkg::BURST_STEP;

  // ------------------------------------------------------------
  // Sweep FSM
  // ------------------------------------------------------------

  // A disable seen mid-handshake takes effect once the burst has retired,
  // so the shared port never sees a request vanish before its ack
  always_comb
  begin
    state_nxt = state;
    addr_nxt  = addr;
    case (state)
      scrub_pkg::IDLE:
        if (enable)
          state_nxt = scrub_pkg::REQ;
      scrub_pkg::REQ:
        if (ack)
          state_nxt = scrub_pkg::WAIT_REL;
      scrub_pkg::WAIT_REL:
        if (!ack)
          state_nxt = scrub_pkg::NEXT;
      scrub_pkg::NEXT:
        if (!enable)
        begin
          state_nxt = scrub_pkg::IDLE;
          addr_nxt  = '0;
        end
        else
        begin
          addr_nxt = addr_step;
          if (addr_step > scrub_pkg::SCRB_MAX_ADDR)
            state_nxt = scrub_pkg::DONE;
          else
            state_nxt = scrub_pkg::REQ;
        end
      scrub_pkg::DONE:
        if (!enable)
        begin
          state_nxt = scrub_pkg::IDLE;
          addr_nxt  = '0;
        end
      default:
      begin
        state_nxt = scrub_pkg::IDLE;
        addr_nxt  = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge sync_rst_n)
    if (!sync_rst_n)
    begin
      state <= scrub_pkg::IDLE;
      addr  <= '0;
    end
    else
    begin
      state <= state_nxt;
      addr  <= addr_nxt;
    end

  // Request is held for the whole REQ state, addr is the burst start
  assign req = (state == scrub_pkg::REQ);

  assign stat.state = state;
  assign stat.done  = (state == scrub_pkg::DONE);
  assign stat.addr  = addr;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  property p_addr_stable;
    @(posedge clk) disable iff (!sync_rst_n)
      req |=> !req || $stable(addr);
  endproperty

  a_addr_stable : assert property (p_addr_stable)
    else $error("scrub_engine addr moved while req was high");

endmodule

/* sim.f */
common/scrub_pkg.sv
design/reset_flr.sv
scrubber/scrub_engine.sv
scrubber/scrub_arbiter.sv
design/scrub_ctrl_status.sv
design/scrub_top.sv
tb/scrub_tb.sv

/* tb/scrub_tb.sv */
// Self-checking testbench for the scrubber top level, compiled from the project root with sim.f
`timescale 1ns/1ps

module scrub_tb;

  localparam int          NUM_ROWS    = 6;
  localparam int          NUM_CHAN    = 4;
  localparam logic [15:0] LAST_ADDR   = 16'h01FF;
  localparam int          BURST_WORDS = 16;
  localparam int          NUM_BURSTS  = (LAST_ADDR + 1) / BURST_WORDS;
  localparam logic [19:0] FILLER      = 20'hA1111;
  localparam logic [3:0]  MARK        = 4'hF;
  localparam logic [31:0] ID_WORD     = 32'h1D0F_ABCD;
  localparam logic [2:0]  ST_DONE     = 3'd4;
  localparam int          SWEEP_LIMIT = 20000;
  localparam int          ACK_LIMIT   = 100;
  localparam int          LOG_DEPTH   = 64;

  logic                clk;
  logic                rst_main_n;
  logic [31:0]         ctl0;
  logic [3:0]          mem_ready;
  logic                flr_assert;
  logic                mem_ack;
  logic                mem_req;
  scrub_pkg::mem_req_t mem_cmd;
  logic [31:0]         status0;
  logic [31:0]         dbg_id;
  logic                flr_done;

  logic [7:0]  lfsr;
  int          errors;
  logic [15:0] seen_addr [0:NUM_CHAN-1][0:LOG_DEPTH-1];
  int          seen_cnt  [0:NUM_CHAN-1];

  // Each row: test name, ctl0 value, mem_ready value, expected done mask
  string       row_name  [0:NUM_ROWS-1] = '{"single_ch0", "single_ch2", "all_channels",
                                            "pair_debug_sel2", "rescrub_ch0_debug_sel7",
                                            "ch3_debug_sel_idle"};
  logic [31:0] row_ctl   [0:NUM_ROWS-1] = '{32'h0000_0001, 32'h0000_0004, 32'h0000_000F,
                                            32'hA000_0005, 32'hF000_0001, 32'h9000_0008};
  logic [3:0]  row_ready [0:NUM_ROWS-1] = '{4'hF, 4'h5, 4'hA, 4'h3, 4'hC, 4'h9};
  logic [3:0]  row_done  [0:NUM_ROWS-1] = '{4'b0001, 4'b0100, 4'b1111,
                                            4'b0101, 4'b0001, 4'b1000};

  scrub_top i_scrub_top
  (
    .clk        (clk),
    .rst_main_n (rst_main_n),
    .ctl0       (ctl0),
    .mem_ready  (mem_ready),
    .flr_assert (flr_assert),
    .mem_ack    (mem_ack),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .status0    (status0),
    .dbg_id     (dbg_id),
    .flr_done   (flr_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // Outputs are settled and inputs are driven 1 ns after the rising edge
  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1, one step per bit
  function automatic int draw_bits(input int n);
    int   val;
    logic fb;
    val = 0;
    for (int b = 0; b < n; b++)
    begin
      fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
      lfsr = {lfsr[6:0], fb};
      val  = (val << 1) | fb;
    end
    return val;
  endfunction

  // Status word once every engine of the row has settled
  function automatic logic [31:0] expect_status(input logic [31:0] ctl, input logic [3:0] ready,
                                                input logic [3:0] done);
    logic [19:0] upper;
    upper = FILLER;
    if (ctl[31])
    begin
      upper = '0;
      for (int i = 0; i < NUM_CHAN; i++)
        if (done[i])
          upper[4 + 4*i +: 3] = ST_DONE;
    end
    return {upper, MARK, done, ready};
  endfunction

  // Finished channels sit one past the region, idle ones at zero
  function automatic logic [31:0] expect_id(input logic [31:0] ctl, input logic [3:0] done);
    int sel;
    sel = ctl[30:28];
    if (sel > 3)
      sel = 0;
    if (!ctl[31])
      return ID_WORD;
    else if (done[sel])
      return 32'(LAST_ADDR) + 1;
    else
      return 32'h0;
  endfunction

  task automatic wait_done(input string name, input logic [3:0] mask);
    int cnt;
    cnt = 0;
    while (status0[7:4] != mask && cnt < SWEEP_LIMIT)
    begin
      next_cycle();
      cnt++;
    end
    if (status0[7:4] != mask)
    begin
      $display("%s: timed out waiting for done mask %b, status0 is %h", name, mask, status0);
      errors++;
    end
  endtask

  // Every enabled channel sees 0, 16, ... in order and each once, others see nothing
  task automatic check_sweep(input string name, input logic [3:0] mask);
    int exp_cnt;
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      exp_cnt = mask[ch] ? NUM_BURSTS : 0;
      if (seen_cnt[ch] != exp_cnt)
      begin
        $display("FAIL %s ch%0d burst count expected %0d actual %0d",
                 name, ch, exp_cnt, seen_cnt[ch]);
        errors++;
      end
      for (int k = 0; k < exp_cnt && k < seen_cnt[ch] && k < LOG_DEPTH; k++)
        if (seen_addr[ch][k] != 16'(k * BURST_WORDS))
        begin
          $display("FAIL %s ch%0d burst %0d addr expected %h actual %h",
                   name, ch, k, 16'(k * BURST_WORDS), seen_addr[ch][k]);
          errors++;
        end
    end
  endtask

  // ------------------------------------------------------------
  // Memory responder
  // ------------------------------------------------------------

  initial
  begin : responder
    int delay;
    int cnt;
    forever
    begin
      next_cycle();
      if (mem_req && !mem_ack)
      begin
        delay = draw_bits(3);
        repeat (delay) next_cycle();
        if (seen_cnt[mem_cmd.chan] < LOG_DEPTH)
          seen_addr[mem_cmd.chan][seen_cnt[mem_cmd.chan]] = mem_cmd.addr;
        seen_cnt[mem_cmd.chan]++;
        mem_ack = 1'b1;
        cnt     = 0;
        while (mem_req && cnt < ACK_LIMIT)
        begin
          next_cycle();
          cnt++;
        end
        if (mem_req)
        begin
          $display("Memory request stayed high long after ack was raised");
          errors++;
        end
        mem_ack = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial
  begin
    logic [31:0] want;
    rst_main_n = 1'b0;
    ctl0       = '0;
    mem_ready  = 4'hF;
    flr_assert = 1'b0;
    mem_ack    = 1'b0;
    lfsr       = 8'd19;
    errors     = 0;
    for (int ch = 0; ch < NUM_CHAN; ch++)
      seen_cnt[ch] = 0;

    repeat (10) next_cycle();
    rst_main_n = 1'b1;
    // Six cycles of reset release, then two register stages into status0
    repeat (10) next_cycle();
    want = expect_status(32'h0, 4'hF, 4'h0);
    if (mem_req !== 1'b0)
    begin
      $display("FAIL reset mem_req expected 0 actual %b", mem_req);
      errors++;
    end
    if (flr_done !== 1'b0)
    begin
      $display("FAIL reset flr_done expected 0 actual %b", flr_done);
      errors++;
    end
    if (status0 !== want)
    begin
      $display("FAIL reset status0 expected %h actual %h", want, status0);
      errors++;
    end
    if (dbg_id !== ID_WORD)
    begin
      $display("FAIL reset dbg_id expected %h actual %h", ID_WORD, dbg_id);
      errors++;
    end

    // FLR done rises two cycles in, then alternates while held
    flr_assert = 1'b1;
    for (int k = 1; k <= 6; k++)
    begin
      next_cycle();
      if (flr_done !== (k % 2 == 0))
      begin
        $display("FAIL flr cycle %0d flr_done expected %b actual %b", k, (k % 2 == 0), flr_done);
        errors++;
      end
    end
    flr_assert = 1'b0;
    repeat (3) next_cycle();
    if (flr_done !== 1'b0)
    begin
      $display("FAIL flr release flr_done expected 0 actual %b", flr_done);
      errors++;
    end

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      // Disabling every channel must clear the done bits
      ctl0 = '0;
      wait_done(row_name[r], 4'h0);
      want = expect_status(32'h0, mem_ready, 4'h0);
      if (status0 !== want)
      begin
        $display("FAIL %s cleared status0 expected %h actual %h", row_name[r], want, status0);
        errors++;
      end
      if (mem_req !== 1'b0)
      begin
        $display("%s: memory request still pending with all channels disabled", row_name[r]);
        errors++;
      end
      for (int ch = 0; ch < NUM_CHAN; ch++)
        seen_cnt[ch] = 0;

      ctl0      = row_ctl[r];
      mem_ready = row_ready[r];
      wait_done(row_name[r], row_done[r]);
      want = expect_status(row_ctl[r], row_ready[r], row_done[r]);
      if (status0 !== want)
      begin
        $display("FAIL %s status0 expected %h actual %h", row_name[r], want, status0);
        errors++;
      end
      want = expect_id(row_ctl[r], row_done[r]);
      if (dbg_id !== want)
      begin
        $display("FAIL %s dbg_id expected %h actual %h", row_name[r], want, dbg_id);
        errors++;
      end
      check_sweep(row_name[r], row_done[r]);
    end

    $display("Scrubber checks finished with %0d errors", errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule
